/* files.f */
+incdir+source
source/pulse_pkg.sv
source/midi_note_tracker.sv
source/note_period_gen.sv
source/edge_sequencer.sv
source/coef_mac.sv
source/pulse_voice_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pulse_voice.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_pulse_voice
FILELIST  := files.f
OBJDIR    := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* testbench/pulse_tests.txt */
# note velocity trigger_interval half_periods hold_triggers
# hold_triggers = round((half_period + 1) / trigger_interval)
127 100 100 4 40
127 127 50 3 80
126 64 97 3 44
125 1 120 3 37
124 20 20 2 237
123 90 200 3 25
120 45 150 2 40
117 110 333 2 21
108 77 400 2 30
127 30 1 2 3986
127 127 2 2 1993

/* testbench/tb_pulse_voice.sv */
// ------------------------------
// Pulse voice testbench
// Notes from a data file, sample
// latency and waveform checks
// ------------------------------
`default_nettype none

`include "pulse_defs.svh"

module tb_pulse_voice import pulse_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        int note;
        int vel;
        int interval;
        int halves;
        int hold;
    } test_vec_t;

    logic      clk;
    logic      reset;
    midi_msg_t midi;
    logic      sample_trig;
    logic      sample_rdy;
    sample_t   sample;

    test_vec_t tests[$];
    int        rdy_due[$];
    int        errors       = 0;
    int        cyc          = 0;
    int        cyc_limit    = 1000000000;
    int        neg_idx      = 0;
    logic      gate_model   = 1'b0;
    int        cur_test     = 0;
    int        amp          = 0;
    int        cur_hold     = 0;
    // Segment index from 0 is rise+, hold+, fall+, fall-, hold- and rise-
    int        seg          = 0;
    int        step         = 0;
    int        hold_cnt     = 0;
    int        holds_done   = 0;
    int        samples_seen = 0;
    logic      sync_lost    = 1'b0;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(16)) u_tb_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    pulse_voice_top u_pulse_voice_top (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_midi        (midi),
        .i_sample_trig (sample_trig),
        .o_sample_rdy  (sample_rdy),
        .o_sample      (sample)
    );

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > cyc_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cyc_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------
    // Sample monitor
    // ------------------------------
    task automatic check_sample(input int got);
        int   lvl;
        int   expv;
        logic done;
        begin
            done = 1'b0;
            while (!done && !sync_lost) begin
                if ((seg == 1) || (seg == 4)) begin
                    expv = (seg == 1) ? amp : -amp;
                    if (got == expv) begin
                        hold_cnt = hold_cnt + 1;
                        done     = 1'b1;
                    end else if (hold_cnt == 0) begin
                        $display("[FAIL] o_sample test %0d sample %0d: got 0x%05h expected 0x%05h",
                                 cur_test, samples_seen, sample_t'(got), sample_t'(expv));
                        errors    = errors + 1;
                        sync_lost = 1'b1;
                    end else begin
                        // Hold is over and the sample belongs to the next ramp
                        if ((holds_done > 0) && ((hold_cnt + 8 < cur_hold - 1) ||
                                                 (hold_cnt + 8 > cur_hold + 1))) begin
                            $display("[FAIL] hold length test %0d: got 0x%0h expected 0x%0h +/- 1",
                                     cur_test, hold_cnt + 8, cur_hold);
                            errors = errors + 1;
                        end
                        holds_done = holds_done + 1;
                        hold_cnt   = 0;
                        seg        = seg + 1;
                    end
                end else begin
                    lvl  = ((seg == 0) || (seg == 3)) ? (2 * step + 1) : (7 - 2 * step);
                    expv = (amp * lvl) / 8;
                    if (seg >= 3) begin
                        expv = -expv;
                    end
                    if (got != expv) begin
                        $display("[FAIL] o_sample test %0d sample %0d: got 0x%05h expected 0x%05h",
                                 cur_test, samples_seen, sample_t'(got), sample_t'(expv));
                        errors    = errors + 1;
                        sync_lost = 1'b1;
                    end
                    step = step + 1;
                    if (step == 4) begin
                        step = 0;
                        seg  = (seg + 1) % 6;
                    end
                    done = 1'b1;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        neg_idx = neg_idx + 1;
        if ((rdy_due.size() != 0) && (rdy_due[0] < neg_idx)) begin
            $display("o_sample_rdy missing for a trigger accepted at cycle %0d", rdy_due[0] - 4);
            errors = errors + 1;
            void'(rdy_due.pop_front());
        end
        if (sample_rdy) begin
            if ((rdy_due.size() == 0) || (rdy_due[0] != neg_idx)) begin
                $display("o_sample_rdy pulsed without an accepted trigger 3 cycles before");
                errors = errors + 1;
            end else begin
                void'(rdy_due.pop_front());
            end
            samples_seen = samples_seen + 1;
            check_sample(int'(sample));
        end else if (sample != '0) begin
            $display("[FAIL] o_sample: got 0x%05h with o_sample_rdy low, expected 0x00000", sample);
            errors = errors + 1;
        end
        // Trigger seen here is sampled on the next rising edge
        if (sample_trig && gate_model) begin
            rdy_due.push_back(neg_idx + `PULSE_MAC_LATENCY + 1);
        end
        if (midi.rdy && (midi.cmd == `MIDI_CMD_NOTE_ON)) begin
            gate_model = 1'b1;
        end else if (midi.rdy && (midi.cmd == `MIDI_CMD_NOTE_OFF)) begin
            gate_model = 1'b0;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_midi(input logic [`MIDI_CMD_W-1:0] code, input int d0, input int d1);
        step_cycle();
        midi = '{rdy: 1'b1, cmd: code, data0: note_t'(d0), data1: velocity_t'(d1)};
        step_cycle();
        midi = '0;
    endtask

    // An interval of one keeps the trigger high
    task automatic fire_trigger(input int interval);
        step_cycle();
        sample_trig = 1'b1;
        if (interval > 1) begin
            step_cycle();
            sample_trig = 1'b0;
            repeat (interval - 2) @(posedge clk);
        end
    endtask

    task automatic load_tests();
        int        fd;
        int        code;
        int        f[5];
        string     line;
        begin
            fd = $fopen("testbench/pulse_tests.txt", "r");
            if (fd == 0) begin
                $display("Could not open testbench/pulse_tests.txt");
                errors = errors + 1;
            end else begin
                while (!$feof(fd)) begin
                    code = $fgets(line, fd);
                    if ((code > 0) && (line.getc(0) != "#")) begin
                        if ($sscanf(line, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]) == 5) begin
                            tests.push_back('{f[0], f[1], f[2], f[3], f[4]});
                        end
                    end
                end
                $fclose(fd);
                if (tests.size() == 0) begin
                    $display("No tests found in testbench/pulse_tests.txt");
                    errors = errors + 1;
                end
            end
        end
    endtask

    task automatic run_note_test(input test_vec_t tv, input int num);
        cur_test     = num;
        amp          = tv.vel << `PULSE_AMP_SHIFT;
        cur_hold     = tv.hold;
        seg          = 0;
        step         = 0;
        hold_cnt     = 0;
        holds_done   = 0;
        samples_seen = 0;
        sync_lost    = 1'b0;
        send_midi(`MIDI_CMD_NOTE_ON, tv.note, tv.vel);
        while ((holds_done < tv.halves) && !sync_lost) begin
            fire_trigger(tv.interval);
        end
        // Later triggers must stay silent
        send_midi(`MIDI_CMD_NOTE_OFF, 0, 0);
        repeat (6) fire_trigger(tv.interval);
        step_cycle();
        sample_trig = 1'b0;
        while (rdy_due.size() != 0) begin
            step_cycle();
        end
        repeat (4) step_cycle();
    endtask

    initial begin
        int err_start;
        int failed;
        midi        = '0;
        sample_trig = 1'b0;
        failed      = 0;
        load_tests();
        cyc_limit = 1000;
        foreach (tests[i]) begin
            cyc_limit = cyc_limit + (tests[i].halves + 1) * (tests[i].hold + 8) * tests[i].interval;
        end
        wait (!reset);
        step_cycle();

        err_start = errors;
        repeat (20) fire_trigger(3);
        step_cycle();
        sample_trig = 1'b0;
        repeat (8) step_cycle();
        if (errors != err_start) begin
            failed = failed + 1;
        end
        $display("test 0 reset and triggers without a note: %s",
                 (errors == err_start) ? "ok" : "failed");

        foreach (tests[i]) begin
            err_start = errors;
            run_note_test(tests[i], i + 1);
            if (errors != err_start) begin
                failed = failed + 1;
            end
            $display("test %0d note %0d vel %0d interval %0d: %s, %0d samples, %0d half-periods",
                     i + 1, tests[i].note, tests[i].vel, tests[i].interval,
                     (errors == err_start) ? "ok" : "failed", samples_seen, holds_done);
        end

        $display("tests %0d, failed %0d, errors %0d", tests.size() + 1, failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ------------------------------
// Testbench clock and reset
// ------------------------------
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release just after an edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* source/pulse_voice_top.sv */
// ------------------------------
// Pulse voice top level
// ------------------------------
`default_nettype none

module pulse_voice_top import pulse_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire midi_msg_t i_midi,
    input  wire logic      i_sample_trig,
    output logic           o_sample_rdy,
    output sample_t        o_sample
);

    note_state_t note;
    logic        period_event;
    logic        clear_event;
    mac_cmd_t    mac_cmd;

    midi_note_tracker u_midi_note_tracker (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_midi  (i_midi),
        .o_note  (note)
    );

    note_period_gen u_note_period_gen (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_note         (note),
        .i_clear_event  (clear_event),
        .o_period_event (period_event)
    );

    edge_sequencer u_edge_sequencer (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_note         (note),
        .i_sample_trig  (i_sample_trig),
        .i_period_event (period_event),
        .o_mac_cmd      (mac_cmd),
        .o_clear_event  (clear_event)
    );

    coef_mac u_coef_mac (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_note       (note),
        .i_mac_cmd    (mac_cmd),
        .o_sample_rdy (o_sample_rdy),
        .o_sample     (o_sample)
    );

endmodule

`default_nettype wire

/* source/coef_mac.sv */
// ------------------------------
// Level times amplitude pipeline
// Three stages, emits sample strobe
// ------------------------------
`default_nettype none

`include "pulse_defs.svh"

module coef_mac import pulse_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire note_state_t i_note,
    input  wire mac_cmd_t    i_mac_cmd,
    output logic             o_sample_rdy,
    output sample_t          o_sample
);

    localparam int AMP_W  = `PULSE_VEL_W + `PULSE_AMP_SHIFT;
    localparam int PROD_W = AMP_W + `PULSE_LEVEL_W;
    localparam int LAT    = `PULSE_MAC_LATENCY;

    logic [LAT-1:0]    vld_q;
    level_t            s1_level;
    logic              s1_neg;
    logic [AMP_W-1:0]  s1_amp;
    logic [PROD_W-1:0] s2_prod;
    logic              s2_neg;
    sample_t           magnitude;

    // Valid shifts alongside the data stages
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAT-2:0], i_mac_cmd.valid};
        end
    end

    always_ff @(posedge i_clk) begin
        s1_level <= i_mac_cmd.level;
        s1_neg   <= i_mac_cmd.negative;
        s1_amp   <= AMP_W'(i_note.velocity) << `PULSE_AMP_SHIFT;
        s2_prod  <= PROD_W'(s1_amp) * PROD_W'(s1_level);
        s2_neg   <= s1_neg;
    end

    // Level is in eighths
    assign magnitude = sample_t'(s2_prod >> 3);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_sample <= '0;
        end else if (vld_q[LAT-2]) begin
            o_sample <= s2_neg ? -magnitude : magnitude;
        end else begin
            o_sample <= '0;
        end
    end

    assign o_sample_rdy = vld_q[LAT-1];

    a_level_in_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        vld_q[0] |-> (s1_level <= level_t'(`PULSE_FULL_LEVEL))
    ) else $error("stage 1 level above full scale");

endmodule

`default_nettype wire

/* source/edge_sequencer.sv */
// ------------------------------
// Edge sequencer
// Walks the level ramps and holds,
// one step per sample trigger
// ------------------------------
`default_nettype none

`include "pulse_defs.svh"

module edge_sequencer import pulse_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire note_state_t i_note,
    input  wire logic        i_sample_trig,
    input  wire logic        i_period_event,
    output mac_cmd_t         o_mac_cmd,
    output logic             o_clear_event
);

    edge_state_t state_q;
    edge_state_t state_d;
    edge_state_t cur_state;
    edge_state_t next_ramp;
    logic [1:0]  step_q;
    logic [1:0]  step_d;
    logic        ramp_up;
    logic        negative;
    mac_cmd_t    cmd_d;
    logic        clear_d;

    // A trigger in IDLE plays the first rise step directly
    assign cur_state = (state_q == IDLE) ? RISE_POS : state_q;

    assign ramp_up  = (cur_state == RISE_POS) || (cur_state == FALL_NEG);
    assign negative = (cur_state == FALL_NEG) || (cur_state == HOLD_NEG) ||
                      (cur_state == RISE_NEG);

    // Successor of each ramp and hold
    always_comb begin
        case (cur_state)
            RISE_POS: next_ramp = HOLD_POS;
            HOLD_POS: next_ramp = FALL_POS;
            FALL_POS: next_ramp = FALL_NEG;
            FALL_NEG: next_ramp = HOLD_NEG;
            HOLD_NEG: next_ramp = RISE_NEG;
            RISE_NEG: next_ramp = RISE_POS;
            default:  next_ramp = RISE_POS;
        endcase
    end

    // ------------------------------
    // Next state and command
    // ------------------------------
    always_comb begin
        state_d = state_q;
        step_d  = step_q;
        cmd_d   = '0;
        clear_d = 1'b0;

        if (!i_note.active) begin
            state_d = IDLE;
            step_d  = '0;
        end else if (i_sample_trig) begin
            cmd_d.valid    = 1'b1;
            cmd_d.negative = negative;
            state_d        = cur_state;

            if ((cur_state == HOLD_POS) || (cur_state == HOLD_NEG)) begin
                cmd_d.level = level_t'(`PULSE_FULL_LEVEL);
                if (i_period_event) begin
                    clear_d = 1'b1;
                    state_d = next_ramp;
                    step_d  = '0;
                end
            end else begin
                // Odd eighths 1,3,5,7 going up or 7,5,3,1 going down
                if (ramp_up) begin
                    cmd_d.level = level_t'({step_q, 1'b1});
                end else begin
                    cmd_d.level = level_t'({~step_q, 1'b1});
                end
                step_d = step_q + 1'b1;
                if (step_q == 2'd3) begin
                    state_d = next_ramp;
                end
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state_q       <= IDLE;
            step_q        <= '0;
            o_mac_cmd     <= '0;
            o_clear_event <= 1'b0;
        end else begin
            state_q       <= state_d;
            step_q        <= step_d;
            o_mac_cmd     <= cmd_d;
            o_clear_event <= clear_d;
        end
    end

    // Clear is registered, so the hold is one cycle back
    a_clear_from_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_clear_event |-> $past((state_q == HOLD_POS) || (state_q == HOLD_NEG))
    ) else $error("event cleared outside a hold");

endmodule

`default_nettype wire

/* source/note_period_gen.sv */
// ------------------------------
// Half-period generator
// Octave table, counter, event latch
// ------------------------------
`default_nettype none

`include "pulse_defs.svh"

module note_period_gen import pulse_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire note_state_t i_note,
    input  wire logic        i_clear_event,
    output logic             o_period_event
);

    logic [3:0] octave;
    logic [3:0] pitch;
    period_t    base;
    period_t    period;
    period_t    cnt_q;
    logic       wrap;

    // ------------------------------
    // Note to period
    // ------------------------------
    assign octave = 4'(i_note.note / 7'd12);
    assign pitch  = 4'(i_note.note % 7'd12);

    always_comb begin
        case (pitch)
            4'd0:    base = `PERIOD_BASE_0;
            4'd1:    base = `PERIOD_BASE_1;
            4'd2:    base = `PERIOD_BASE_2;
            4'd3:    base = `PERIOD_BASE_3;
            4'd4:    base = `PERIOD_BASE_4;
            4'd5:    base = `PERIOD_BASE_5;
            4'd6:    base = `PERIOD_BASE_6;
            4'd7:    base = `PERIOD_BASE_7;
            4'd8:    base = `PERIOD_BASE_8;
            4'd9:    base = `PERIOD_BASE_9;
            4'd10:   base = `PERIOD_BASE_10;
            4'd11:   base = `PERIOD_BASE_11;
            default: base = `PERIOD_BASE_0;
        endcase
    end

    // Each octave up halves the period
    assign period = base >> octave;

    // ------------------------------
    // Counter and event latch
    // ------------------------------
    // Also catches a count left above a newly lowered period
    assign wrap = (cnt_q >= period);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cnt_q <= '0;
        end else if (!i_note.active || wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_period_event <= 1'b0;
        end else if (i_note.active && wrap) begin
            o_period_event <= 1'b1;
        end else if (i_clear_event || !i_note.active) begin
            // Stale event dropped while the voice is silent
            o_period_event <= 1'b0;
        end
    end

    a_cnt_in_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $stable(period) |-> (cnt_q <= period)
    ) else $error("period counter above period");

endmodule

`default_nettype wire

/* source/midi_note_tracker.sv */
// ------------------------------
// MIDI note tracker
// Holds note, velocity and gate
// ------------------------------
`default_nettype none

`include "pulse_defs.svh"

module midi_note_tracker import pulse_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire midi_msg_t   i_midi,
    output note_state_t      o_note
);

    logic      note_on_stb;
    logic      note_off_stb;
    logic      active_q;
    note_t     note_q;
    velocity_t velocity_q;

    // Channel nibble is not carried so any channel plays
    assign note_on_stb  = i_midi.rdy && (i_midi.cmd == `MIDI_CMD_NOTE_ON);
    assign note_off_stb = i_midi.rdy && (i_midi.cmd == `MIDI_CMD_NOTE_OFF);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            active_q <= 1'b0;
        end else if (note_on_stb) begin
            active_q <= 1'b1;
        end else if (note_off_stb) begin
            active_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (note_on_stb) begin
            note_q     <= i_midi.data0;
            velocity_q <= i_midi.data1;
        end
    end

    assign o_note = '{active: active_q, note: note_q, velocity: velocity_q};

    a_gate_needs_note_on: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $rose(active_q) |-> $past(note_on_stb)
    ) else $error("note gate rose without a note-on");

endmodule

`default_nettype wire

/* source/pulse_pkg.sv */
// ------------------------------
// Pulse voice types: vectors,
// message structs, sequencer states
// ------------------------------
`default_nettype none

`include "pulse_defs.svh"

package pulse_pkg;

    typedef logic [`PULSE_NOTE_W-1:0]          note_t;
    typedef logic [`PULSE_VEL_W-1:0]           velocity_t;
    typedef logic [`PULSE_PERIOD_W-1:0]        period_t;
    typedef logic [`PULSE_LEVEL_W-1:0]         level_t;
    typedef logic signed [`PULSE_SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic                   rdy;
        logic [`MIDI_CMD_W-1:0] cmd;
        note_t                  data0;
        velocity_t              data1;
    } midi_msg_t;

    typedef struct packed {
        logic      active;
        note_t     note;
        velocity_t velocity;
    } note_state_t;

    // One command per accepted trigger
    typedef struct packed {
        logic   valid;
        level_t level;
        logic   negative;
    } mac_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        RISE_POS,
        HOLD_POS,
        FALL_POS,
        FALL_NEG,
        HOLD_NEG,
        RISE_NEG
    } edge_state_t;

endpackage

`default_nettype wire

/* source/pulse_defs.svh */
// ------------------------------
// Pulse voice widths, MIDI codes,
// octave table and pipeline depth
// ------------------------------
`ifndef PULSE_DEFS_SVH
`define PULSE_DEFS_SVH

`define PULSE_NOTE_W        7
`define PULSE_VEL_W         7
`define PULSE_PERIOD_W      24
`define PULSE_SAMPLE_W      18
`define PULSE_LEVEL_W       4
`define PULSE_FULL_LEVEL    8
`define PULSE_AMP_SHIFT     10

`define MIDI_CMD_W          4
`define MIDI_CMD_NOTE_ON    4'h9
`define MIDI_CMD_NOTE_OFF   4'h8

// Half-periods of the lowest octave, in clocks
`define PERIOD_BASE_0       24'h5d5084
`define PERIOD_BASE_1       24'h5813c2
`define PERIOD_BASE_2       24'h532240
`define PERIOD_BASE_3       24'h4e77c5
`define PERIOD_BASE_4       24'h4a1054
`define PERIOD_BASE_5       24'h45e82b
`define PERIOD_BASE_6       24'h41fbbc
`define PERIOD_BASE_7       24'h3e47ac
`define PERIOD_BASE_8       24'h3ac8d3
`define PERIOD_BASE_9       24'h377c32
`define PERIOD_BASE_10      24'h345efa
`define PERIOD_BASE_11      24'h316e80

`define PULSE_MAC_LATENCY   3

`endif
